/* source/mpeg_defines.svh */
`ifndef MPEG_DEFINES_SVH
`define MPEG_DEFINES_SVH

// audio and video stream ids.
`define STREAM_ID_MIN 8'hC0
`define STREAM_ID_MAX 8'hEF

`define MAX_STUFFING 16

`define REG_FILTER  8'h00
`define REG_STATUS  8'h04
`define REG_PTS_LO  8'h08
`define REG_PTS_HI  8'h0C
`define REG_DTS_LO  8'h10
`define REG_DTS_HI  8'h14
`define REG_PKT_CNT 8'h18
`define REG_ERR_CNT 8'h1C

`endif

/* source/mpeg_pkg.sv */
package mpeg_pkg;

  // header form after the buffer-size field.
  typedef enum logic [1:0] {
    TS_NONE    = 2'd0,
    TS_PTS     = 2'd1,
    TS_PTS_DTS = 2'd2
  } ts_kind_e;

  typedef enum logic [2:0] {
    LEN_HI   = 3'd0,
    LEN_LO   = 3'd1,
    STUFF    = 3'd2,
    STD_2ND  = 3'd3,
    TS_FIELD = 3'd4,
    PAYLOAD  = 3'd5
  } parse_state_e;

  // one decoded time stamp field, 77 bits.
  typedef struct packed {
    logic [7:0]  stream_id;
    ts_kind_e    kind;
    logic [32:0] pts;
    logic [32:0] dts;
    logic        marker_err;
  } ts_record_t;

endpackage

/* source/byte_stream_if.sv */
`timescale 1ns/1ps

interface byte_stream_if;

  logic [7:0] data;
  logic       valid;
  logic       first;     // start of a section, meaning depends on the link.
  logic [7:0] stream_id;

  modport src (
    output data,
    output valid,
    output first,
    output stream_id
  );

  modport snk (
    input data,
    input valid,
    input first,
    input stream_id
  );

endinterface

/* source/start_code_detector.sv */
`timescale 1ns/1ps
`include "mpeg_defines.svh"

module start_code_detector (
  input  logic       read_signal,
  input  logic       rst,
  input  logic [7:0] in_data,
  input  logic       in_valid,
  byte_stream_if.src out
);

  logic [7:0] hist0;
  logic [7:0] hist1;
  logic       id_next;    // next byte is the stream id.
  logic       fwd_en;
  logic       first_pend;
  logic [7:0] cur_id;
  logic       prefix_hit;
  logic       id_in_range;

  assign prefix_hit  = (hist1 == 8'h00) && (hist0 == 8'h00) && (in_data == 8'h01);
  assign id_in_range = (in_data >= `STREAM_ID_MIN) && (in_data <= `STREAM_ID_MAX);

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      hist0      <= 8'hFF; // no false prefix out of reset.
      hist1      <= 8'hFF;
      id_next    <= 1'b0;
      fwd_en     <= 1'b0;
      first_pend <= 1'b0;
      out.valid  <= 1'b0;
      out.first  <= 1'b0;
    end
    else
    begin
      out.valid <= 1'b0;
      out.first <= 1'b0;
      if (in_valid)
      begin
        hist1 <= hist0;
        hist0 <= in_data;
        if (id_next)
        begin
          id_next    <= 1'b0;
          fwd_en     <= id_in_range; // pack and system headers stop here.
          first_pend <= 1'b1;
        end
        else if (prefix_hit)
        begin
          id_next <= 1'b1;
          fwd_en  <= 1'b0;
        end
        else if (fwd_en)
        begin
          out.valid  <= 1'b1;
          out.first  <= first_pend;
          first_pend <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (in_valid && id_next)
    begin
      cur_id <= in_data;
    end
    out.data      <= in_data;
    out.stream_id <= cur_id;
  end

endmodule

/* source/pes_header_parser.sv */
`timescale 1ns/1ps
`include "mpeg_defines.svh"

module pes_header_parser (
  input  logic       read_signal,
  input  logic       rst,
  byte_stream_if.snk in,
  byte_stream_if.src out
);

  import mpeg_pkg::*;

  parse_state_e state;
  logic [15:0]  len_left;   // bytes left in the packet.
  logic [4:0]   stuff_cnt;
  logic [3:0]   ts_left;
  logic [3:0]   ts_more;
  logic         in_body;

  // bytes that follow the first one of the stamp field.
  always_comb
  begin
    case (in.data[7:4])
      4'b0010: ts_more = 4'd4;
      4'b0011: ts_more = 4'd9;
      default: ts_more = 4'd0;
    endcase
  end

  assign in_body = (state != LEN_HI) && (state != LEN_LO);

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      state     <= LEN_HI;
      len_left  <= 16'd0;
      stuff_cnt <= 5'd0;
      ts_left   <= 4'd0;
      out.valid <= 1'b0;
      out.first <= 1'b0;
    end
    else
    begin
      out.valid <= 1'b0;
      out.first <= 1'b0;
      if (in.valid && in.first)
      begin
        len_left[15:8] <= in.data; // length high byte opens every packet.
        state          <= LEN_LO;
      end
      else if (in.valid)
      begin
        case (state)
          LEN_HI: ; // idle until the next packet.
          LEN_LO:
          begin
            len_left[7:0] <= in.data;
            stuff_cnt     <= 5'd0;
            if ({len_left[15:8], in.data} == 16'd0)
              state <= LEN_HI;
            else
              state <= STUFF;
          end
          STUFF:
          begin
            if ((in.data == 8'hFF) && (stuff_cnt < 5'(`MAX_STUFFING)))
            begin
              stuff_cnt <= stuff_cnt + 5'd1;
            end
            else if (in.data[7:6] == 2'b01)
            begin
              state <= STD_2ND; // buffer-size field, dropped.
            end
            else
            begin
              out.valid <= 1'b1;
              out.first <= 1'b1;
              ts_left   <= ts_more;
              state     <= (ts_more != 4'd0) ? TS_FIELD : PAYLOAD;
            end
          end
          STD_2ND: state <= STUFF;
          TS_FIELD:
          begin
            out.valid <= 1'b1;
            ts_left   <= ts_left - 4'd1;
            if (ts_left == 4'd1)
              state <= PAYLOAD;
          end
          default: out.valid <= 1'b1; // payload.
        endcase

        if (in_body)
        begin
          len_left <= len_left - 16'd1;
          if (len_left == 16'd1)
            state <= LEN_HI;
        end
      end
    end
  end

  always_ff @(posedge read_signal)
  begin
    out.data      <= in.data;
    out.stream_id <= in.stream_id;
  end

endmodule

/* source/time_stamps.sv */
`timescale 1ns/1ps

module time_stamps (
  input  logic                 read_signal,
  input  logic                 rst,
  byte_stream_if.snk           in,
  output mpeg_pkg::ts_record_t rec,
  output logic                 rec_valid
);

  import mpeg_pkg::*;

  logic        busy;
  logic [3:0]  idx;        // byte index inside the stamp field.
  logic [3:0]  last_idx;
  ts_kind_e    kind;
  logic [7:0]  sid;
  logic [32:0] pts;
  logic [32:0] dts;
  logic        marker_err;
  logic        in_dts;
  logic [2:0]  pos;

  // 3 + 8 + 7 + 8 + 7 bit slicing of one five-byte group.
  function automatic logic [32:0] put_field(input logic [32:0] v,
                                            input logic [2:0]  p,
                                            input logic [7:0]  d);
    logic [32:0] r;
    r = v;
    case (p)
      3'd0:    r[32:30] = d[3:1];
      3'd1:    r[29:22] = d;
      3'd2:    r[21:15] = d[7:1];
      3'd3:    r[14:7]  = d;
      default: r[6:0]   = d[7:1];
    endcase
    return r;
  endfunction

  assign in_dts = (idx >= 4'd5);
  assign pos    = in_dts ? 3'(idx - 4'd5) : idx[2:0];

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      busy       <= 1'b0;
      idx        <= 4'd0;
      last_idx   <= 4'd0;
      kind       <= TS_NONE;
      marker_err <= 1'b0;
      rec_valid  <= 1'b0;
    end
    else
    begin
      rec_valid <= 1'b0;
      if (in.valid && in.first)
      begin
        idx <= 4'd1;
        case (in.data[7:4])
          4'b0010:
          begin
            kind       <= TS_PTS;
            busy       <= 1'b1;
            last_idx   <= 4'd4;
            marker_err <= ~in.data[0];
          end
          4'b0011:
          begin
            kind       <= TS_PTS_DTS;
            busy       <= 1'b1;
            last_idx   <= 4'd9;
            marker_err <= ~in.data[0];
          end
          default:
          begin
            kind       <= TS_NONE;
            busy       <= 1'b0;
            rec_valid  <= 1'b1;
            marker_err <= (in.data != 8'h0F); // unknown form.
          end
        endcase
      end
      else if (in.valid && busy)
      begin
        idx <= idx + 4'd1;
        if (!pos[0])
          marker_err <= marker_err | ~in.data[0]; // bytes 0, 2 and 4.
        if (idx == last_idx)
        begin
          busy      <= 1'b0;
          rec_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (in.valid && in.first)
    begin
      sid <= in.stream_id;
      dts <= 33'd0;
      if (in.data[7:5] == 3'b001)
        pts <= put_field(33'd0, 3'd0, in.data);
      else
        pts <= 33'd0;
    end
    else if (in.valid && busy)
    begin
      if (in_dts)
        dts <= put_field(dts, pos, in.data);
      else
        pts <= put_field(pts, pos, in.data);
    end
  end

  assign rec = '{stream_id: sid, kind: kind, pts: pts, dts: dts, marker_err: marker_err};

endmodule

/* source/ts_axil_regs.sv */
`timescale 1ns/1ps
`include "mpeg_defines.svh"

module ts_axil_regs (
  input  logic                 read_signal,
  input  logic                 rst,
  input  mpeg_pkg::ts_record_t rec,
  input  logic                 rec_valid,
  input  logic [7:0]           awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [31:0]          wdata,
  input  logic [3:0]           wstrb,
  input  logic                 wvalid,
  output logic                 wready,
  output logic [1:0]           bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic [7:0]           araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic [31:0]          rdata,
  output logic [1:0]           rresp,
  output logic                 rvalid,
  input  logic                 rready
);

  import mpeg_pkg::*;

  logic [7:0]  filter;
  logic [7:0]  last_id;
  ts_kind_e    last_kind;
  logic [32:0] last_pts;
  logic [32:0] last_dts;
  logic        new_rec;
  logic [31:0] pkt_cnt;
  logic [31:0] err_cnt;
  logic        accept;
  logic        rd_hs;
  logic [31:0] rd_mux;

  assign accept = rec_valid && ((filter == 8'd0) || (filter == rec.stream_id));
  assign rd_hs  = arready && arvalid;
  assign bresp  = 2'b00;
  assign rresp  = 2'b00;

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      filter  <= 8'd0;
    end
    else
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (awvalid && wvalid && !bvalid && !awready)
      begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (awready && awvalid && wvalid)
      begin
        bvalid <= 1'b1;
        if ((awaddr == `REG_FILTER) && wstrb[0])
          filter <= wdata[7:0];
      end
      else if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_hs)
        rvalid <= 1'b1;
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  always_comb
  begin
    case (araddr)
      `REG_FILTER:  rd_mux = {24'd0, filter};
      `REG_STATUS:  rd_mux = {15'd0, new_rec, 6'd0, last_kind, last_id};
      `REG_PTS_LO:  rd_mux = last_pts[31:0];
      `REG_PTS_HI:  rd_mux = {31'd0, last_pts[32]};
      `REG_DTS_LO:  rd_mux = last_dts[31:0];
      `REG_DTS_HI:  rd_mux = {31'd0, last_dts[32]};
      `REG_PKT_CNT: rd_mux = pkt_cnt;
      `REG_ERR_CNT: rd_mux = err_cnt;
      default:      rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge read_signal)
  begin
    if (rd_hs)
      rdata <= rd_mux; // held while rready is low.
  end

  always_ff @(posedge read_signal)
  begin
    if (rst)
    begin
      last_id   <= 8'd0;
      last_kind <= TS_NONE;
      last_pts  <= 33'd0;
      last_dts  <= 33'd0;
      new_rec   <= 1'b0;
      pkt_cnt   <= 32'd0;
      err_cnt   <= 32'd0;
    end
    else
    begin
      if (accept)
      begin
        last_id   <= rec.stream_id;
        last_kind <= rec.kind;
        last_pts  <= rec.pts;
        last_dts  <= rec.dts;
        pkt_cnt   <= pkt_cnt + 32'd1;
        if (rec.marker_err)
          err_cnt <= err_cnt + 32'd1;
      end
      // a fresh record wins over a clearing read.
      if (accept)
        new_rec <= 1'b1;
      else if (rd_hs && (araddr == `REG_STATUS))
        new_rec <= 1'b0;
    end
  end

endmodule

/* source/pes_demux_top.sv */
`timescale 1ns/1ps

module pes_demux_top (
  input  logic        read_signal,
  input  logic        rst,
  input  logic [7:0]  in_data,
  input  logic        in_valid,
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  import mpeg_pkg::*;

  ts_record_t rec;
  logic       rec_valid;

  byte_stream_if s_pes ();  // bytes after the stream id.
  byte_stream_if s_ts ();   // stamp field onward.

  start_code_detector i_scd (
    .read_signal (read_signal),
    .rst         (rst),
    .in_data     (in_data),
    .in_valid    (in_valid),
    .out         (s_pes)
  );

  pes_header_parser i_hdr (
    .read_signal (read_signal),
    .rst         (rst),
    .in          (s_pes),
    .out         (s_ts)
  );

  time_stamps i_ts (
    .read_signal (read_signal),
    .rst         (rst),
    .in          (s_ts),
    .rec         (rec),
    .rec_valid   (rec_valid)
  );

  ts_axil_regs i_regs (
    .read_signal (read_signal),
    .rst         (rst),
    .rec         (rec),
    .rec_valid   (rec_valid),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready)
  );

endmodule

/* tb/tb_pes_demux.sv */
`timescale 1ns/1ps
`include "mpeg_defines.svh"

module tb_pes_demux;

  import mpeg_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int PIPE_LAT    = 4;  // last stamp byte to register update.
  localparam int N_PKTS      = 8;
  localparam int MAX_PKT_LEN = 6 + `MAX_STUFFING + 2 + 10 + 8;
  localparam int N_AXIL      = 40;
  localparam int AXIL_CYC    = 12;
  localparam int WATCHDOG_NS = (N_PKTS * (MAX_PKT_LEN + PIPE_LAT + 4) + N_AXIL * AXIL_CYC + 200)
                               * CLK_PERIOD;

  logic        read_signal;
  logic        rst;
  logic [7:0]  in_data;
  logic        in_valid;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  int          n_errors;
  int          n_checks;
  int          exp_pkt;
  int          exp_err;
  logic [7:0]  pkt_q[$];

  pes_demux_top i_dut (
    .read_signal (read_signal),
    .rst         (rst),
    .in_data     (in_data),
    .in_valid    (in_valid),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready)
  );

  initial
  begin
    read_signal = 1'b0;
    forever #(CLK_PERIOD / 2) read_signal = ~read_signal;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  function automatic logic [32:0] rand33();
    logic [32:0] v;
    v[31:0] = $urandom;
    v[32]   = $urandom_range(1, 0);
    return v;
  endfunction

  function automatic logic [31:0] status_word(input logic [7:0] id, input ts_kind_e kind,
                                              input logic fresh);
    return {15'd0, fresh, 6'd0, 2'(kind), id};
  endfunction

  task automatic drive_bytes();
    foreach (pkt_q[i])
    begin
      @(posedge read_signal);
      in_data  <= pkt_q[i];
      in_valid <= 1'b1;
    end
    @(posedge read_signal);
    in_valid <= 1'b0;
    repeat (PIPE_LAT + 2) @(posedge read_signal); // fixed pipeline depth.
  endtask

  // five-byte group of prefix, 3 + 8 + 7 + 8 + 7 bits and marker bits.
  task automatic push_stamp(input logic [3:0] prefix, input logic [32:0] v, input bit bad_marker);
    pkt_q.push_back({prefix, v[32:30], ~bad_marker});
    pkt_q.push_back(v[29:22]);
    pkt_q.push_back({v[21:15], 1'b1});
    pkt_q.push_back(v[14:7]);
    pkt_q.push_back({v[6:0], 1'b1});
  endtask

  task automatic send_packet(input logic [7:0] id, input ts_kind_e kind,
                             input logic [32:0] pts, input logic [32:0] dts,
                             input int n_stuff, input bit with_std, input bit bad_marker);
    int ts_len;
    int n_pay;
    int len;
    ts_len = (kind == TS_PTS) ? 5 : ((kind == TS_PTS_DTS) ? 10 : 1);
    n_pay  = 1 + ($urandom % 8);
    len    = n_stuff + (with_std ? 2 : 0) + ts_len + n_pay;
    pkt_q.delete();
    pkt_q.push_back(8'h00);
    pkt_q.push_back(8'h00);
    pkt_q.push_back(8'h01);
    pkt_q.push_back(id);
    pkt_q.push_back(8'(len >> 8));
    pkt_q.push_back(8'(len));
    repeat (n_stuff)
      pkt_q.push_back(8'hFF);
    if (with_std)
    begin
      pkt_q.push_back(8'h40 | 8'($urandom % 64)); // buffer-size field.
      pkt_q.push_back(8'($urandom));
    end
    case (kind)
      TS_PTS: push_stamp(4'b0010, pts, bad_marker);
      TS_PTS_DTS:
      begin
        push_stamp(4'b0011, pts, bad_marker);
        push_stamp(4'b0001, dts, 1'b0);
      end
      default: pkt_q.push_back(8'h0F);
    endcase
    repeat (n_pay)
      pkt_q.push_back(8'(1 + ($urandom % 255))); // nonzero, never part of a prefix.
    drive_bytes();
  endtask

  task automatic send_pack_header();
    pkt_q = {8'h00, 8'h00, 8'h01, 8'hBA, 8'h21, 8'h00, 8'h01, 8'h00, 8'h01, 8'h80, 8'h1B, 8'h91};
    drive_bytes();
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge read_signal);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hF;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(posedge read_signal);
    while (!(awready && wready))
      @(posedge read_signal);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge read_signal);
    while (!bvalid)
      @(posedge read_signal);
    check_eq("bresp", 32'(bresp), 32'd0);
    bready <= 1'b0;
  endtask

  // hold > 0 keeps rready low for that many cycles once rvalid is up.
  task automatic axil_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
    @(posedge read_signal);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= (hold == 0);
    @(posedge read_signal);
    while (!arready)
      @(posedge read_signal);
    arvalid <= 1'b0;
    @(posedge read_signal);
    while (!rvalid)
      @(posedge read_signal);
    data = rdata;
    check_eq("rresp", 32'(rresp), 32'd0);
    if (hold > 0)
    begin
      araddr <= addr ^ 8'h04; // another register, rdata must not follow it.
      repeat (hold)
      begin
        @(posedge read_signal);
        check_eq("rvalid", 32'(rvalid), 32'd1);
        check_eq("rdata", rdata, data);
      end
      rready <= 1'b1;
      @(posedge read_signal);
    end
    rready <= 1'b0;
  endtask

  task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] v;
    axil_read(addr, 0, v);
    check_eq(name, v, exp);
  endtask

  task automatic check_stamps(input logic [32:0] pts, input logic [32:0] dts);
    read_check("pts_lo", `REG_PTS_LO, pts[31:0]);
    read_check("pts_hi", `REG_PTS_HI, {31'd0, pts[32]});
    read_check("dts_lo", `REG_DTS_LO, dts[31:0]);
    read_check("dts_hi", `REG_DTS_HI, {31'd0, dts[32]});
  endtask

  task automatic test_pts_only();
    logic [32:0] pts;
    pts = rand33();
    send_packet(8'hE0, TS_PTS, pts, 33'd0, 0, 1'b0, 1'b0);
    exp_pkt++;
    read_check("status", `REG_STATUS, status_word(8'hE0, TS_PTS, 1'b1));
    check_stamps(pts, 33'd0);
    read_check("pkt_cnt", `REG_PKT_CNT, 32'(exp_pkt));
  endtask

  task automatic test_pts_dts();
    logic [32:0] pts;
    logic [32:0] dts;
    pts = rand33();
    dts = rand33();
    send_packet(8'hC0, TS_PTS_DTS, pts, dts, $urandom % (`MAX_STUFFING + 1), 1'b1, 1'b0);
    exp_pkt++;
    read_check("status", `REG_STATUS, status_word(8'hC0, TS_PTS_DTS, 1'b1));
    check_stamps(pts, dts);
    read_check("pkt_cnt", `REG_PKT_CNT, 32'(exp_pkt));
  endtask

  task automatic test_no_stamp_and_marker();
    send_packet(8'hE1, TS_NONE, 33'd0, 33'd0, 2, 1'b0, 1'b0);
    exp_pkt++;
    read_check("status", `REG_STATUS, status_word(8'hE1, TS_NONE, 1'b1));
    check_stamps(33'd0, 33'd0);
    read_check("err_cnt", `REG_ERR_CNT, 32'(exp_err));
    send_packet(8'hE0, TS_PTS, rand33(), 33'd0, 1, 1'b0, 1'b1); // byte 0 marker cleared.
    exp_pkt++;
    exp_err++;
    read_check("err_cnt", `REG_ERR_CNT, 32'(exp_err));
    read_check("pkt_cnt", `REG_PKT_CNT, 32'(exp_pkt));
  endtask

  task automatic test_stream_filter();
    logic [32:0] a;
    a = rand33();
    axil_write(`REG_FILTER, 32'h0000_00C1);
    read_check("filter", `REG_FILTER, 32'h0000_00C1);
    send_packet(8'hC1, TS_PTS, a, 33'd0, 0, 1'b1, 1'b0);
    exp_pkt++;
    read_check("pkt_cnt", `REG_PKT_CNT, 32'(exp_pkt));
    read_check("status", `REG_STATUS, status_word(8'hC1, TS_PTS, 1'b1));
    read_check("pts_lo", `REG_PTS_LO, a[31:0]);
    axil_write(`REG_FILTER, 32'd0); // every id passes while the pack header goes by.
    send_pack_header();
    read_check("pkt_cnt", `REG_PKT_CNT, 32'(exp_pkt));
    axil_write(`REG_FILTER, 32'h0000_00C1);
    send_packet(8'hE2, TS_PTS, rand33(), 33'd0, 0, 1'b0, 1'b0);
    read_check("pkt_cnt", `REG_PKT_CNT, 32'(exp_pkt));
    read_check("status", `REG_STATUS, status_word(8'hC1, TS_PTS, 1'b0));
    read_check("pts_lo", `REG_PTS_LO, a[31:0]);
    axil_write(`REG_FILTER, 32'd0);
  endtask

  task automatic test_status_and_reads();
    logic [32:0] pts;
    logic [31:0] v;
    pts = rand33();
    send_packet(8'hE0, TS_PTS, pts, 33'd0, 3, 1'b0, 1'b0);
    exp_pkt++;
    read_check("status", `REG_STATUS, status_word(8'hE0, TS_PTS, 1'b1));
    read_check("status", `REG_STATUS, status_word(8'hE0, TS_PTS, 1'b0));
    axil_read(`REG_PTS_LO, 3, v);
    check_eq("pts_lo", v, pts[31:0]);
    read_check("unmapped", 8'h20, 32'd0);
    read_check("unmapped", 8'hFC, 32'd0);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    n_errors = 0;
    n_checks = 0;
    exp_pkt  = 0;
    exp_err  = 0;
    void'($urandom(32'h8225));
    rst      <= 1'b1;
    in_data  <= 8'd0;
    in_valid <= 1'b0;
    awaddr   <= 8'd0;
    awvalid  <= 1'b0;
    wdata    <= 32'd0;
    wstrb    <= 4'd0;
    wvalid   <= 1'b0;
    bready   <= 1'b0;
    araddr   <= 8'd0;
    arvalid  <= 1'b0;
    rready   <= 1'b0;
    repeat (5) @(posedge read_signal);
    rst <= 1'b0;
    @(posedge read_signal);
    test_pts_only();
    test_pts_dts();
    test_no_stamp_and_marker();
    test_stream_filter();
    test_status_and_reads();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* flist.f */
+incdir+source
source/mpeg_pkg.sv
source/byte_stream_if.sv
source/start_code_detector.sv
source/pes_header_parser.sv
source/time_stamps.sv
source/ts_axil_regs.sv
source/pes_demux_top.sv
tb/tb_pes_demux.sv

/* Bender.yml */
package:
  name: pes_demux

export_include_dirs:
  - source

sources:
  - files:
      - source/mpeg_pkg.sv
      - source/byte_stream_if.sv
      - source/start_code_detector.sv
      - source/pes_header_parser.sv
      - source/time_stamps.sv
      - source/ts_axil_regs.sv
      - source/pes_demux_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_pes_demux.sv
